// File: design/branch_resolver.sv
// decode-stage jump detection, target adder and exception vector select
`timescale 1ns/1ps

module branch_resolver
   import fetch_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic [INSN_WIDTH-1:0]    decode_insn_i,
   input  logic                     decode_bubble_i,
   input  logic [OPERAND_WIDTH-1:0] decode_pc_i,
   input  logic                     padv_i,
   input  logic                     fetch_take_exception_branch_i,
   output logic                     branch_occur_o,
   output logic [OPERAND_WIDTH-1:0] branch_dest_o
);

   logic [OPCODE_WIDTH-1:0]  opcode;
   logic [OFFSET_WIDTH-1:0]  offset;
   logic [OPERAND_WIDTH-1:0] offset_bytes;
   logic [OPERAND_WIDTH-1:0] jump_target;
   logic                     is_jump;
   // set once the jump in decode has advanced
   logic                     jump_done_r;

   assign opcode = decode_insn_i[INSN_WIDTH-1:OPCODE_LSB];
   assign offset = decode_insn_i[OFFSET_WIDTH-1:0];

   // J and JAL only, no conditional or register jumps here
   assign is_jump = (opcode == OPC_J) | (opcode == OPC_JAL);

   // word offset, sign extended then scaled to bytes
   assign offset_bytes = {{(OPERAND_WIDTH-OFFSET_WIDTH-2){offset[OFFSET_WIDTH-1]}},
                          offset, 2'b00};

   assign jump_target = decode_pc_i + offset_bytes;

   assign branch_occur_o = is_jump & !decode_bubble_i & !jump_done_r;

   // exception restart overrides the jump target
   assign branch_dest_o = fetch_take_exception_branch_i ? EXCEPT_VECTOR : jump_target;

   // one delay slot per jump
   always_ff @(posedge clk)
   begin
      if (rst || fetch_take_exception_branch_i)
         jump_done_r <= 1'b0;
      else if (padv_i)
         jump_done_r <= branch_occur_o;
   end

endmodule

// File: design/fetch_core_top.sv
// top level joining rom, fetch unit, branch resolver and pipeline control
`timescale 1ns/1ps

module fetch_core_top
   import fetch_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      stall_i,
   input  logic                      prog_we_i,
   input  logic [ROM_ADDR_WIDTH-1:0] prog_adr_i,
   input  logic [INSN_WIDTH-1:0]     prog_dat_i,
   output logic                      issue_valid_o,
   output logic [OPERAND_WIDTH-1:0]  issue_pc_o,
   output logic [INSN_WIDTH-1:0]     issue_insn_o,
   output logic                      except_valid_o,
   output logic [OPERAND_WIDTH-1:0]  except_pc_o
);

   // instruction bus
   logic [OPERAND_WIDTH-1:0] ibus_adr;
   logic                     ibus_req;
   logic                     ibus_ack;
   logic                     ibus_err;
   logic [INSN_WIDTH-1:0]    ibus_dat;
   // fetch and decode
   logic [INSN_WIDTH-1:0]    decode_insn;
   logic                     decode_bubble;
   logic                     decode_except_ibus_err;
   logic                     next_fetch_done;
   logic                     fetch_advancing;
   logic [OPERAND_WIDTH-1:0] pc_fetch;
   logic [OPERAND_WIDTH-1:0] decode_pc;
   // control
   logic                     padv;
   logic                     execute_waiting;
   logic                     fetch_take_exception_branch;
   logic                     branch_occur;
   logic [OPERAND_WIDTH-1:0] branch_dest;

   assign issue_pc_o     = decode_pc;
   assign issue_insn_o   = decode_insn;
   assign except_valid_o = fetch_take_exception_branch;

   ibus_rom rom0 (
      .clk(clk), .rst(rst),
      .prog_we_i(prog_we_i), .prog_adr_i(prog_adr_i), .prog_dat_i(prog_dat_i),
      .ibus_req_i(ibus_req), .ibus_adr_i(ibus_adr),
      .ibus_ack_o(ibus_ack), .ibus_err_o(ibus_err), .ibus_dat_o(ibus_dat)
   );

   insn_fetch fetch0 (
      .clk(clk), .rst(rst),
      .ibus_adr_o(ibus_adr), .ibus_req_o(ibus_req),
      .ibus_ack_i(ibus_ack), .ibus_err_i(ibus_err), .ibus_dat_i(ibus_dat),
      .padv_i(padv), .branch_occur_i(branch_occur), .branch_dest_i(branch_dest),
      .fetch_take_exception_branch_i(fetch_take_exception_branch),
      .execute_waiting_i(execute_waiting), .du_stall_i(stall_i),
      .decode_insn_o(decode_insn), .decode_bubble_o(decode_bubble),
      .decode_except_ibus_err_o(decode_except_ibus_err),
      .next_fetch_done_o(next_fetch_done), .fetch_advancing_o(fetch_advancing),
      .pc_fetch_o(pc_fetch)
   );

   branch_resolver branch0 (
      .clk(clk), .rst(rst),
      .decode_insn_i(decode_insn), .decode_bubble_i(decode_bubble),
      .decode_pc_i(decode_pc), .padv_i(padv),
      .fetch_take_exception_branch_i(fetch_take_exception_branch),
      .branch_occur_o(branch_occur), .branch_dest_o(branch_dest)
   );

   pipe_ctrl ctrl0 (
      .clk(clk), .rst(rst), .stall_i(stall_i),
      .next_fetch_done_i(next_fetch_done), .decode_insn_i(decode_insn),
      .decode_bubble_i(decode_bubble), .decode_except_ibus_err_i(decode_except_ibus_err),
      .pc_fetch_i(pc_fetch), .fetch_advancing_i(fetch_advancing),
      .padv_o(padv), .execute_waiting_o(execute_waiting),
      .fetch_take_exception_branch_o(fetch_take_exception_branch),
      .decode_pc_o(decode_pc), .issue_valid_o(issue_valid_o), .except_pc_o(except_pc_o)
   );

endmodule

// File: design/fetch_pkg.sv
// widths, opcode fields, vectors, rom size and bus latency for the fetch front end
package fetch_pkg;

   // datapath widths
   localparam int OPERAND_WIDTH = 32;
   localparam int INSN_WIDTH    = 32;

   // opcode sits in the top six bits of every instruction
   localparam int OPCODE_WIDTH  = 6;
   localparam int OPCODE_LSB    = INSN_WIDTH - OPCODE_WIDTH;

   // jump word offset, signed, in the low bits
   localparam int OFFSET_WIDTH  = 26;

   // opcodes used by the front end
   localparam logic [OPCODE_WIDTH-1:0] OPC_J    = 6'h00;
   localparam logic [OPCODE_WIDTH-1:0] OPC_JAL  = 6'h01;
   localparam logic [OPCODE_WIDTH-1:0] OPC_NOP  = 6'h05;
   // multi-cycle class
   localparam logic [OPCODE_WIDTH-1:0] OPC_MULI = 6'h2c;
   localparam logic [OPCODE_WIDTH-1:0] OPC_ALU  = 6'h38;

   // canonical nop, opcode then zeros
   localparam logic [INSN_WIDTH-1:0] NOP_INSN = {OPC_NOP, {OFFSET_WIDTH{1'b0}}};

   // fetch start and bus error restart
   localparam logic [OPERAND_WIDTH-1:0] RESET_PC      = 32'h0000_0000;
   localparam logic [OPERAND_WIDTH-1:0] EXCEPT_VECTOR = 32'h0000_0100;

   // program rom, word addressed
   localparam int ROM_WORDS      = 256;
   localparam int ROM_ADDR_WIDTH = 8;
   // first byte address past the rom
   localparam logic [OPERAND_WIDTH-1:0] ROM_BYTES = ROM_WORDS * 4;

   // request to reply, in cycles
   localparam int IBUS_LATENCY  = 2;
   localparam int LAT_CNT_WIDTH = 2;

   // execute hold of a MULI
   localparam int MUL_CYCLES    = 3;
   localparam int MUL_CNT_WIDTH = 2;

endpackage

// File: design/ibus_rom.sv
// program rom with fixed-latency request/acknowledge instruction bus
`timescale 1ns/1ps

module ibus_rom
   import fetch_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      prog_we_i,
   input  logic [ROM_ADDR_WIDTH-1:0] prog_adr_i,
   input  logic [INSN_WIDTH-1:0]     prog_dat_i,
   input  logic                      ibus_req_i,
   input  logic [OPERAND_WIDTH-1:0]  ibus_adr_i,
   output logic                      ibus_ack_o,
   output logic                      ibus_err_o,
   output logic [INSN_WIDTH-1:0]     ibus_dat_o
);

   logic [INSN_WIDTH-1:0]    mem [ROM_WORDS];
   logic [LAT_CNT_WIDTH-1:0] lat_cnt;
   logic [OPERAND_WIDTH-1:0] adr_q;
   logic                     req_q;
   logic                     in_range;

   assign in_range = ibus_adr_i < ROM_BYTES;

   // program port only takes writes while the core is held in reset
   always_ff @(posedge clk)
   begin
      if (rst && prog_we_i)
         mem[prog_adr_i] <= prog_dat_i;
   end

   // read data for the addressed word
   always_ff @(posedge clk)
   begin
      ibus_dat_o <= mem[ibus_adr_i[ROM_ADDR_WIDTH+1:2]];
   end

   // latency counter restarts on a new address or a dropped request
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         lat_cnt    <= '0;
         adr_q      <= RESET_PC;
         req_q      <= 1'b0;
         ibus_ack_o <= 1'b0;
         ibus_err_o <= 1'b0;
      end
      else
      begin
         adr_q      <= ibus_adr_i;
         req_q      <= ibus_req_i;
         ibus_ack_o <= 1'b0;
         ibus_err_o <= 1'b0;
         if (!ibus_req_i)
            lat_cnt <= '0;
         else if (!req_q || ibus_adr_i != adr_q)
            // first sample of this request
            lat_cnt <= LAT_CNT_WIDTH'(1);
         else if (lat_cnt == LAT_CNT_WIDTH'(IBUS_LATENCY - 1))
         begin
            // reply now as a one-cycle pulse
            ibus_ack_o <= in_range;
            ibus_err_o <= !in_range;
            lat_cnt    <= '0;
         end
         else
            lat_cnt <= lat_cnt + 1'b1;
      end
   end

endmodule

// File: design/insn_fetch.sv
// fetch unit with one-instruction buffer, fetch pc, branch and exception redirect
`timescale 1ns/1ps

module insn_fetch
   import fetch_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   // instruction bus
   output logic [OPERAND_WIDTH-1:0] ibus_adr_o,
   output logic                     ibus_req_o,
   input  logic                     ibus_ack_i,
   input  logic                     ibus_err_i,
   input  logic [INSN_WIDTH-1:0]    ibus_dat_i,
   // pipeline control
   input  logic                     padv_i,
   input  logic                     branch_occur_i,
   input  logic [OPERAND_WIDTH-1:0] branch_dest_i,
   input  logic                     fetch_take_exception_branch_i,
   input  logic                     execute_waiting_i,
   input  logic                     du_stall_i,
   // decode side
   output logic [INSN_WIDTH-1:0]    decode_insn_o,
   output logic                     decode_bubble_o,
   output logic                     decode_except_ibus_err_o,
   output logic                     next_fetch_done_o,
   output logic                     fetch_advancing_o,
   output logic [OPERAND_WIDTH-1:0] pc_fetch_o
);

   // fetch state
   logic [OPERAND_WIDTH-1:0] pc_fetch;
   logic                     fetch_req;
   logic [INSN_WIDTH-1:0]    insn_buffer;
   logic                     next_insn_buffered;
   // buffered entry is a bus error, not an instruction
   logic                     buffer_err;
   logic                     wait_for_exception_after_ibus_err;
   logic                     advancing_into_branch;

   logic                     taking_branch;
   logic                     bus_access_done;

   // jump in decode leaves on this advance
   assign taking_branch = branch_occur_i & padv_i;

   // replies right after a redirect belong to the old stream
   assign bus_access_done = (ibus_ack_i | ibus_err_i) & !taking_branch &
                            !advancing_into_branch;

   assign ibus_adr_o = pc_fetch;
   assign ibus_req_o = fetch_req;
   assign pc_fetch_o = pc_fetch;

   // buffer holds the next decode entry
   assign next_fetch_done_o = next_insn_buffered & !advancing_into_branch;

   assign fetch_advancing_o = padv_i & next_fetch_done_o & !execute_waiting_i;

   // fetch pc names the buffered entry until it moves into decode
   always_ff @(posedge clk)
   begin
      if (rst)
         pc_fetch <= RESET_PC;
      else if (fetch_take_exception_branch_i)
         pc_fetch <= branch_dest_i;
      else if (fetch_advancing_o && !buffer_err)
         pc_fetch <= taking_branch ? branch_dest_i : pc_fetch + 32'd4;
   end

   // bus request, address is held steady while it is high
   always_ff @(posedge clk)
   begin
      if (rst)
         fetch_req <= 1'b1;
      else if (fetch_take_exception_branch_i)
         fetch_req <= 1'b1;
      else if (bus_access_done)
         // buffer now full
         fetch_req <= 1'b0;
      else if (fetch_advancing_o)
         // a faulting entry waits for the exception instead
         fetch_req <= !buffer_err & !du_stall_i;
      else if (du_stall_i)
         // drop it, the rom restarts its count later at the same pc
         fetch_req <= 1'b0;
      else if (!next_insn_buffered && !wait_for_exception_after_ibus_err)
         fetch_req <= 1'b1;
   end

   // one-entry buffer flag
   always_ff @(posedge clk)
   begin
      if (rst)
         next_insn_buffered <= 1'b0;
      else if (fetch_take_exception_branch_i)
         next_insn_buffered <= 1'b0;
      else if (bus_access_done)
         next_insn_buffered <= 1'b1;
      else if (fetch_advancing_o)
         next_insn_buffered <= 1'b0;
   end

   // buffer payload
   always_ff @(posedge clk)
   begin
      if (bus_access_done)
      begin
         insn_buffer <= ibus_err_i ? NOP_INSN : ibus_dat_i;
         buffer_err  <= ibus_err_i;
      end
   end

   // no further fetches between an error and its exception
   always_ff @(posedge clk)
   begin
      if (rst)
         wait_for_exception_after_ibus_err <= 1'b0;
      else if (fetch_take_exception_branch_i)
         wait_for_exception_after_ibus_err <= 1'b0;
      else if (bus_access_done && ibus_err_i)
         wait_for_exception_after_ibus_err <= 1'b1;
   end

   // remembers the cycle a jump left decode
   always_ff @(posedge clk)
   begin
      if (rst)
         advancing_into_branch <= 1'b0;
      else
         advancing_into_branch <= fetch_advancing_o & branch_occur_i;
   end

   // decode register, nop bubbles on reset, exception and error entries
   always_ff @(posedge clk)
   begin
      if (rst || fetch_take_exception_branch_i)
      begin
         decode_insn_o            <= NOP_INSN;
         decode_bubble_o          <= 1'b1;
         decode_except_ibus_err_o <= 1'b0;
      end
      else if (fetch_advancing_o)
      begin
         decode_insn_o            <= insn_buffer;
         decode_bubble_o          <= buffer_err;
         decode_except_ibus_err_o <= buffer_err;
      end
   end

endmodule

// File: design/pipe_ctrl.sv
// pipeline control with advance strobe, multiply hold, decode pc and exceptions
`timescale 1ns/1ps

module pipe_ctrl
   import fetch_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     stall_i,
   input  logic                     next_fetch_done_i,
   input  logic [INSN_WIDTH-1:0]    decode_insn_i,
   input  logic                     decode_bubble_i,
   input  logic                     decode_except_ibus_err_i,
   input  logic [OPERAND_WIDTH-1:0] pc_fetch_i,
   input  logic                     fetch_advancing_i,
   output logic                     padv_o,
   output logic                     execute_waiting_o,
   output logic                     fetch_take_exception_branch_o,
   output logic [OPERAND_WIDTH-1:0] decode_pc_o,
   output logic                     issue_valid_o,
   output logic [OPERAND_WIDTH-1:0] except_pc_o
);

   logic [MUL_CNT_WIDTH-1:0] mul_cnt;
   logic                     issue_muli;

   // advance needs a fetched entry and a free execute stage
   assign padv_o = next_fetch_done_i & !execute_waiting_o & !stall_i &
                   !decode_except_ibus_err_i;

   // bubbles leave decode silently
   assign issue_valid_o = padv_o & !decode_bubble_i;

   assign issue_muli = issue_valid_o &
                       (decode_insn_i[INSN_WIDTH-1:OPCODE_LSB] == OPC_MULI);

   assign execute_waiting_o = mul_cnt != '0;

   // error entry in decode starts the exception, fetch clears it next edge
   assign fetch_take_exception_branch_o = decode_except_ibus_err_i;
   assign except_pc_o = decode_pc_o;

   // multiply hold, counts down after each issued MULI
   always_ff @(posedge clk)
   begin
      if (rst)
         mul_cnt <= '0;
      else if (issue_muli)
         mul_cnt <= MUL_CNT_WIDTH'(MUL_CYCLES);
      else if (execute_waiting_o)
         mul_cnt <= mul_cnt - 1'b1;
   end

   // decode pc follows the entry moving out of the fetch buffer
   always_ff @(posedge clk)
   begin
      if (rst)
         decode_pc_o <= RESET_PC;
      else if (fetch_advancing_i)
         decode_pc_o <= pc_fetch_i;
   end

endmodule

// File: fetch_core_top.f
design/fetch_pkg.sv
design/ibus_rom.sv
design/insn_fetch.sv
design/branch_resolver.sv
design/pipe_ctrl.sv
design/fetch_core_top.sv
tests/tb_fetch_core.sv

// File: tests/tb_fetch_core.sv
// testbench with random program generator, architectural model, stall driver and compare tasks
`timescale 1ns/1ps

module tb_fetch_core
   import fetch_pkg::*;
();

   localparam int NUM_ISSUES       = 3000;
   localparam int RST_CYCLES       = 10;
   localparam int EXC_WORD         = EXCEPT_VECTOR / 4;
   // straight-line words at the exception vector
   localparam int EXC_REGION_WORDS = 16;

   typedef struct packed {
      logic                     is_except;
      logic [OPERAND_WIDTH-1:0] pc;
      logic [INSN_WIDTH-1:0]    insn;
   } exp_event_t;

   logic                      clk = 1'b0;
   logic                      rst;
   logic                      stall_i = 1'b0;
   logic                      prog_we_i;
   logic [ROM_ADDR_WIDTH-1:0] prog_adr_i;
   logic [INSN_WIDTH-1:0]     prog_dat_i;
   logic                      issue_valid_o;
   logic [OPERAND_WIDTH-1:0]  issue_pc_o;
   logic [INSN_WIDTH-1:0]     issue_insn_o;
   logic                      except_valid_o;
   logic [OPERAND_WIDTH-1:0]  except_pc_o;

   logic [INSN_WIDTH-1:0] prog [ROM_WORDS];
   exp_event_t            exp_q [$];
   logic [31:0]           rng_state;
   int                    stall_left = 0;
   int                    mul_hold = 0;
   int                    cycle_cnt = 0;
   int                    timeout_limit = 1000;
   int                    errors = 0;
   int                    issued = 0;
   int                    excepts = 0;

   fetch_core_top dut0 (
      .clk(clk), .rst(rst), .stall_i(stall_i),
      .prog_we_i(prog_we_i), .prog_adr_i(prog_adr_i), .prog_dat_i(prog_dat_i),
      .issue_valid_o(issue_valid_o), .issue_pc_o(issue_pc_o), .issue_insn_o(issue_insn_o),
      .except_valid_o(except_valid_o), .except_pc_o(except_pc_o)
   );

   // 4 ns period
   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_failed();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic report_mismatch(input string msg);
      errors++;
      $display("[ERROR] %0t: %s", $time, msg);
      stop_failed();
   endtask

   task automatic abort_run(input string msg);
      errors++;
      $display("%s", msg);
      stop_failed();
   endtask

   // random program, jumps never in a delay slot, the last word or the vector region
   task automatic build_program();
      int   w;
      int   sel;
      int   tgt;
      logic prev_jump;
      logic in_exc_region;
      prev_jump = 1'b0;
      for (w = 0; w < ROM_WORDS; w++)
      begin
         rng_state = xorshift(rng_state);
         sel = int'(rng_state[3:0]);
         in_exc_region = (w >= EXC_WORD) && (w < EXC_WORD + EXC_REGION_WORDS);
         if (sel >= 12 && !prev_jump && !in_exc_region && w != ROM_WORDS - 1)
         begin
            rng_state = xorshift(rng_state);
            // mostly forward in range, sometimes past the end or below zero
            if (rng_state[2:0] == 3'd0 || w + 2 > ROM_WORDS - 1)
               tgt = rng_state[3] ? ROM_WORDS + int'(rng_state[9:4]) : -1 - int'(rng_state[9:4]);
            else
               tgt = w + 2 + int'(rng_state[31:8] % (ROM_WORDS - 2 - w));
            prog[w] = {(sel == 15) ? OPC_JAL : OPC_J, OFFSET_WIDTH'(tgt - w)};
            prev_jump = 1'b1;
         end
         else
         begin
            if (sel >= 8)
               prog[w] = {OPC_MULI, rng_state[29:4]};
            else if (sel >= 6)
               prog[w] = NOP_INSN;
            else
               prog[w] = {OPC_ALU, rng_state[29:4]};
            prev_jump = 1'b0;
         end
      end
   endtask

   // architectural model, one entry per expected issue or exception
   task automatic build_expected();
      logic [OPERAND_WIDTH-1:0] pc;
      logic [INSN_WIDTH-1:0]    insn;
      logic [OPCODE_WIDTH-1:0]  opc;
      int                       off_words;
      int                       count;
      pc = RESET_PC;
      count = 0;
      while (count < NUM_ISSUES)
      begin
         if (pc >= OPERAND_WIDTH'(ROM_WORDS * 4))
         begin
            // bus error, restart at the vector
            exp_q.push_back({1'b1, pc, NOP_INSN});
            pc = EXCEPT_VECTOR;
         end
         else
         begin
            insn = prog[int'(pc >> 2)];
            opc = insn[INSN_WIDTH-1 -: OPCODE_WIDTH];
            exp_q.push_back({1'b0, pc, insn});
            count++;
            if (opc == OPC_J || opc == OPC_JAL)
            begin
               // delay slot always issues, then the target
               exp_q.push_back({1'b0, pc + 32'd4, prog[int'((pc + 32'd4) >> 2)]});
               count++;
               off_words = $signed(insn[OFFSET_WIDTH-1:0]);
               pc = pc + OPERAND_WIDTH'(off_words * 4);
            end
            else
               pc = pc + 32'd4;
         end
      end
   endtask

   task automatic check_issue(input logic [OPERAND_WIDTH-1:0] pc,
                              input logic [INSN_WIDTH-1:0]    insn);
      exp_event_t exp;
      if (exp_q.size() == 0)
         abort_run("an instruction was issued after the expected stream had ended");
      else
      begin
         exp = exp_q.pop_front();
         issued++;
         if (exp.is_except)
            report_mismatch($sformatf("issue pc %h insn %h, expected exception at %h",
                                      pc, insn, exp.pc));
         else if (pc !== exp.pc || insn !== exp.insn)
            report_mismatch($sformatf("issue pc %h insn %h, expected pc %h insn %h",
                                      pc, insn, exp.pc, exp.insn));
      end
   endtask

   task automatic check_except(input logic [OPERAND_WIDTH-1:0] pc);
      exp_event_t exp;
      if (exp_q.size() == 0)
         abort_run("an exception was raised after the expected stream had ended");
      else
      begin
         exp = exp_q.pop_front();
         excepts++;
         if (!exp.is_except)
            report_mismatch($sformatf("exception at pc %h, expected issue of pc %h",
                                      pc, exp.pc));
         else if (pc !== exp.pc)
            report_mismatch($sformatf("exception pc %h, expected %h", pc, exp.pc));
      end
   endtask

   // random stall pulses of one to four cycles
   always @(posedge clk)
   begin
      if (rst)
      begin
         stall_left = 0;
         stall_i <= 1'b0;
      end
      else
      begin
         if (stall_left == 0)
         begin
            rng_state = xorshift(rng_state);
            if (rng_state[3:0] == 4'd0)
               stall_left = 1 + int'(rng_state[9:8]);
         end
         else
            stall_left = stall_left - 1;
         stall_i <= (stall_left != 0);
      end
   end

   // outputs are settled at the falling edge
   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (issue_valid_o && except_valid_o)
            abort_run("an issue and an exception pulsed in the same cycle");
         else if (issue_valid_o && mul_hold != 0)
            abort_run("an instruction issued while a MULI still held execute");
         else
         begin
            if (mul_hold != 0)
               mul_hold = mul_hold - 1;
            if (except_valid_o)
               check_except(except_pc_o);
            else if (issue_valid_o)
            begin
               if (issue_insn_o[INSN_WIDTH-1 -: OPCODE_WIDTH] == OPC_MULI)
                  mul_hold = MUL_CYCLES;
               check_issue(issue_pc_o, issue_insn_o);
            end
         end
      end
   end

   // watchdog
   always @(posedge clk)
   begin
      if (!rst)
      begin
         cycle_cnt = cycle_cnt + 1;
         if (cycle_cnt > timeout_limit)
            abort_run($sformatf("timeout: the DUT hung after %0d cycles, %0d events missing",
                                cycle_cnt, exp_q.size()));
      end
   end

   initial
   begin
      rst        <= 1'b1;
      prog_we_i  <= 1'b0;
      prog_adr_i <= '0;
      prog_dat_i <= '0;
      rng_state = 32'he9d3;
      build_program();
      build_expected();
      timeout_limit = 40 * exp_q.size() + 1000;
      // rom takes writes only in reset, so the load runs first
      for (int w = 0; w < ROM_WORDS; w++)
      begin
         @(posedge clk);
         prog_we_i  <= 1'b1;
         prog_adr_i <= ROM_ADDR_WIDTH'(w);
         prog_dat_i <= prog[w];
      end
      @(posedge clk);
      prog_we_i <= 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      while (exp_q.size() != 0)
         @(posedge clk);
      $display("issued %0d instructions, %0d exceptions", issued, excepts);
      if (errors == 0)
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
      else
         stop_failed();
   end

endmodule
